// ==== hdl/sifhParamPkg.sv ====
// SiFH parameter set
// sizes of samples, histograms and passes, plus the bus address map
package sifhParamPkg;

    // ********************
    // sample and histogram
    localparam int NP = 8;
    localparam int NB = 4;
    localparam int BIN_NUM = 2 ** NB;
    localparam int PEAK_W = 8;
    localparam int SB = 2 ** (NB - 1);
    localparam logic [NP-1:0] NO_DATA = '1;

    // ********************
    // frame organisation
    localparam int PIXEL_NUM = 4;
    localparam int DATA_NUM = 4;
    localparam int ACQ_NUM = 8;
    localparam int DRAIN_CYCLES = 4;
    localparam int FRAME_W = 8;

    // counter widths
    localparam int PIX_W = $clog2(PIXEL_NUM);
    localparam int DATA_W = $clog2(DATA_NUM);
    localparam int ACQ_W = $clog2(ACQ_NUM);
    localparam int DRAIN_W = $clog2(DRAIN_CYCLES);

    // ********************
    // bus map, result of pixel p at ADR_RESULT + p
    localparam int ADR_W = 3;
    localparam logic [ADR_W-1:0] ADR_SAMPLE = 3'd0;
    localparam logic [ADR_W-1:0] ADR_RESULT = 3'd4;

endpackage

// ==== hdl/sifhTypesPkg.sv ====
// SiFH shared types
// bus request/response, pipeline beats, pass and sequencer states,
// per-pixel windows, peaks and results
package sifhTypesPkg;
    import sifhParamPkg::*;

    // ********************
    // states
    typedef enum logic {PASS_COARSE, PASS_FINE} pass_e;
    typedef enum logic {SEQ_RUN, SEQ_DRAIN} seqState_e;

    // ********************
    // wishbone classic
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [ADR_W-1:0] adr;
        logic [NP+FRAME_W-1:0] dat;
    } wbReq_t;

    typedef struct packed {
        logic ack;
        logic [NP+FRAME_W-1:0] dat;
    } wbRsp_t;

    // ********************
    // pipeline beats
    typedef struct packed {
        logic valid;
        logic [PIX_W-1:0] pixel;
        logic [NP-1:0] sample;
    } sampleIn_t;

    typedef struct packed {
        logic valid;
        logic [PIX_W-1:0] pixel;
        logic [NB-1:0] bin;
    } binBeat_t;

    typedef struct packed {
        logic valid;
        logic [PIX_W-1:0] pixel;
        logic [NB-1:0] bin;
        logic [PEAK_W-1:0] count;
    } binHit_t;

    // fine pass window on the full sample scale
    typedef struct packed {
        logic [NP-1:0] thMinus;
        logic [NP-1:0] thPlus;
    } window_t;

    typedef window_t [PIXEL_NUM-1:0] windowArr_t;
    typedef logic [PIXEL_NUM-1:0][NB-1:0] peakArr_t;
    typedef logic [PIXEL_NUM-1:0][NP-1:0] resultArr_t;

endpackage

// ==== hdl/wbSamplePort.sv ====
`timescale 1ns/10ps
// Wishbone classic slave of the peak finder
// sample writes go to the sequencer, reads return status or results;
// ack is held off while the pipeline drains
module wbSamplePort (
    input  logic                                clk,
    input  logic                                combin_res,
    input  sifhTypesPkg::wbReq_t                wbReq,
    output sifhTypesPkg::wbRsp_t                wbRsp,
    input  logic                                busy,
    input  sifhTypesPkg::pass_e                 pass,
    input  logic [sifhParamPkg::FRAME_W-1:0]    frameCount,
    input  sifhTypesPkg::resultArr_t            results,
    output logic                                sampleAccept,
    output logic [sifhParamPkg::NP-1:0]         sampleData
);
    import sifhParamPkg::*;
    import sifhTypesPkg::*;

    logic ack;
    logic reqSeen;
    logic isSample;
    logic isResult;
    logic [PIX_W-1:0] resIdx;
    logic [NP+FRAME_W-1:0] rdNext;
    logic [NP+FRAME_W-1:0] rdData;

    // new request, not during the ack cycle and not while draining
    assign reqSeen = wbReq.cyc && wbReq.stb && !ack && !busy;

    // address decode
    assign isSample = wbReq.adr == ADR_SAMPLE;
    assign isResult = (wbReq.adr >= ADR_RESULT) &&
                      (int'(wbReq.adr) < int'(ADR_RESULT) + PIXEL_NUM);
    assign resIdx = PIX_W'(wbReq.adr - ADR_RESULT);

    // read mux, status is frame count on top and pass in bit 0
    always_comb begin
        if (isSample) begin
            rdNext = {frameCount, {(NP - 1){1'b0}}, pass == PASS_FINE};
        end else if (isResult) begin
            rdNext = {{FRAME_W{1'b0}}, results[resIdx]};
        end else begin
            rdNext = '0;
        end
    end

    // one clock ack, sample strobe goes out with it
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            ack <= 1'b0;
            sampleAccept <= 1'b0;
        end else begin
            ack <= reqSeen;
            sampleAccept <= reqSeen && wbReq.we && isSample;
        end
    end

    // data registers
    always_ff @(posedge clk) begin
        if (reqSeen) begin
            rdData <= rdNext;
            sampleData <= wbReq.dat[NP-1:0];
        end
    end

    assign wbRsp = '{ack: ack, dat: rdData};

endmodule

// ==== hdl/frameSequencer.sv ====
`timescale 1ns/10ps
// frame sequencer
// tags accepted samples with their pixel, counts acquisitions,
// drains the pipeline at pass end and alternates coarse and fine passes
module frameSequencer (
    input  logic                                clk,
    input  logic                                combin_res,
    input  logic                                sampleAccept,
    input  logic [sifhParamPkg::NP-1:0]         sampleData,
    output sifhTypesPkg::sampleIn_t             sampleOut,
    output sifhTypesPkg::pass_e                 pass,
    output logic                                busy,
    output logic                                passEnd,
    output logic [sifhParamPkg::FRAME_W-1:0]    frameCount
);
    import sifhParamPkg::*;
    import sifhTypesPkg::*;

    logic [DATA_W-1:0] dataCnt;
    logic [PIX_W-1:0] pixCnt;
    logic [ACQ_W-1:0] acqCnt;
    logic [DRAIN_W-1:0] drainCnt;
    seqState_e state;
    logic dataWrap;
    logic pixWrap;
    logic lastSample;

    assign dataWrap = dataCnt == DATA_W'(DATA_NUM - 1);
    assign pixWrap = pixCnt == PIX_W'(PIXEL_NUM - 1);
    assign lastSample = dataWrap && pixWrap && (acqCnt == ACQ_W'(ACQ_NUM - 1));

    // sample with its pixel index
    assign sampleOut = '{valid: sampleAccept, pixel: pixCnt, sample: sampleData};

    assign busy = state == SEQ_DRAIN;
    assign passEnd = busy && (drainCnt == DRAIN_W'(DRAIN_CYCLES - 1));

    // ********************
    // data / pixel / acquisition counters
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            dataCnt <= '0;
            pixCnt <= '0;
            acqCnt <= '0;
        end else if (sampleAccept) begin
            dataCnt <= dataWrap ? '0 : dataCnt + 1'b1;
            if (dataWrap) begin
                pixCnt <= pixWrap ? '0 : pixCnt + 1'b1;
                // all pixels done, next round
                if (pixWrap) begin
                    acqCnt <= lastSample ? '0 : acqCnt + 1'b1;
                end
            end
        end
    end

    // ********************
    // pass FSM and drain
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state <= SEQ_RUN;
            drainCnt <= '0;
            pass <= PASS_COARSE;
            frameCount <= '0;
        end else begin
            case (state)
                SEQ_RUN: begin
                    if (sampleAccept && lastSample) begin
                        state <= SEQ_DRAIN;
                        drainCnt <= '0;
                    end
                end
                SEQ_DRAIN: begin
                    drainCnt <= drainCnt + 1'b1;
                    if (passEnd) begin
                        state <= SEQ_RUN;
                        pass <= (pass == PASS_COARSE) ? PASS_FINE : PASS_COARSE;
                        // a fine pass closes the frame
                        if (pass == PASS_FINE) begin
                            frameCount <= frameCount + 1'b1;
                        end
                    end
                end
                default: state <= SEQ_RUN;
            endcase
        end
    end

endmodule

// ==== hdl/sampleFilter.sv ====
`timescale 1ns/10ps
// sample filter
// coarse pass: top NB bits are the bin, no-data samples dropped
// fine pass: offset inside the pixel window is the bin
module sampleFilter (
    input  logic                        clk,
    input  logic                        combin_res,
    input  sifhTypesPkg::sampleIn_t     sampleIn,
    input  sifhTypesPkg::pass_e         pass,
    input  sifhTypesPkg::windowArr_t    windows,
    output sifhTypesPkg::binBeat_t      beat
);
    import sifhParamPkg::*;
    import sifhTypesPkg::*;

    window_t win;
    logic [NP-1:0] offset;
    logic inWindow;
    binBeat_t beatNext;

    // window of the incoming pixel
    assign win = windows[sampleIn.pixel];
    assign offset = sampleIn.sample - win.thMinus;
    assign inWindow = (sampleIn.sample >= win.thMinus) && (sampleIn.sample <= win.thPlus);

    always_comb begin
        beatNext.pixel = sampleIn.pixel;
        if (pass == PASS_COARSE) begin
            beatNext.bin = sampleIn.sample[NP-1 -: NB];
            beatNext.valid = sampleIn.valid && (sampleIn.sample != NO_DATA);
        end else begin
            beatNext.bin = offset[NB-1:0];
            // top bin reserved, window never reaches no-data
            beatNext.valid = sampleIn.valid && inWindow && (offset < NP'(BIN_NUM - 1));
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            beat <= '0;
        end else begin
            beat <= beatNext;
        end
    end

endmodule

// ==== hdl/binHistogram.sv ====
`timescale 1ns/10ps
// per-pixel bin histogram
// PIXEL_NUM x BIN_NUM saturating counters, read-modify-write in one cycle;
// a valid flag per bin lets the whole histogram clear in one clock
module binHistogram (
    input  logic                        clk,
    input  logic                        combin_res,
    input  sifhTypesPkg::binBeat_t      beat,
    input  logic                        clear,
    output sifhTypesPkg::binHit_t       hit
);
    import sifhParamPkg::*;

    // ********************
    // storage
    logic [PEAK_W-1:0] counts [PIXEL_NUM*BIN_NUM];
    logic [PIXEL_NUM*BIN_NUM-1:0] binValid;

    logic [PIX_W+NB-1:0] addr;
    logic [PEAK_W-1:0] curCount;
    logic [PEAK_W-1:0] newCount;

    // pixel selects the block, bin the entry
    assign addr = {beat.pixel, beat.bin};
    assign curCount = counts[addr];

    // ********************
    // increment
    always_comb begin
        if (!binValid[addr]) begin
            // first hit since clear
            newCount = PEAK_W'(1);
        end else if (curCount == '1) begin
            newCount = curCount;
        end else begin
            newCount = curCount + 1'b1;
        end
    end

    // write back, a following hit on the same bin reads the new value
    always_ff @(posedge clk) begin
        if (beat.valid) begin
            counts[addr] <= newCount;
        end
    end

    // flags
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            binValid <= '0;
        end else if (clear) begin
            binValid <= '0;
        end else if (beat.valid) begin
            binValid[addr] <= 1'b1;
        end
    end

    // ********************
    // hit out to the tracker
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit <= '0;
        end else begin
            hit.valid <= beat.valid;
            hit.pixel <= beat.pixel;
            hit.bin <= beat.bin;
            hit.count <= newCount;
        end
    end

endmodule

// ==== hdl/peakTracker.sv ====
`timescale 1ns/10ps
// running peak tracker
// keeps the highest count and its bin per pixel;
// only a strictly greater count moves the peak, so ties keep the first bin
module peakTracker (
    input  logic                        clk,
    input  logic                        combin_res,
    input  sifhTypesPkg::binHit_t       hit,
    input  logic                        clear,
    output sifhTypesPkg::peakArr_t      peaks
);
    import sifhParamPkg::*;
    import sifhTypesPkg::*;

    logic [PIXEL_NUM-1:0][PEAK_W-1:0] best;
    peakArr_t bestBin;
    logic newBest;

    // compare against the stored best of that pixel
    assign newBest = hit.valid && (hit.count > best[hit.pixel]);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            best <= '0;
            bestBin <= '0;
        end else if (clear) begin
            // empty pixel reports bin 0
            best <= '0;
            bestBin <= '0;
        end else if (newBest) begin
            best[hit.pixel] <= hit.count;
            bestBin[hit.pixel] <= hit.bin;
        end
    end

    assign peaks = bestBin;

endmodule

// ==== hdl/peakRefine.sv ====
`timescale 1ns/10ps
// peak refinement
// coarse pass end: window [thMinus, thPlus] around each coarse peak
// fine pass end: result = fine peak + thMinus
module peakRefine (
    input  logic                        clk,
    input  logic                        combin_res,
    input  logic                        passEnd,
    input  sifhTypesPkg::pass_e         pass,
    input  sifhTypesPkg::peakArr_t      peaks,
    output sifhTypesPkg::windowArr_t    windows,
    output sifhTypesPkg::resultArr_t    results
);
    import sifhParamPkg::*;
    import sifhTypesPkg::*;

    logic [PIXEL_NUM-1:0][NP-1:0] ch;
    windowArr_t winNext;

    // ********************
    // window rule
    always_comb begin
        for (int p = 0; p < PIXEL_NUM; p++) begin
            // coarse bin back on the full scale
            ch[p] = {peaks[p], {(NP - NB){1'b0}}};
            if (ch[p] > NO_DATA - NP'(2 * SB + 1)) begin
                // pinned below the no-data code
                winNext[p].thPlus = NO_DATA - NP'(1);
                winNext[p].thMinus = NO_DATA - NP'(2 * SB + 1);
            end else if (ch[p] <= NP'(SB)) begin
                winNext[p].thMinus = '0;
                winNext[p].thPlus = NP'(2 * SB);
            end else begin
                winNext[p].thMinus = ch[p] - NP'(SB);
                winNext[p].thPlus = ch[p] + NP'(SB);
            end
        end
    end

    // ********************
    // latch at pass end
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            windows <= '0;
            results <= '0;
        end else if (passEnd) begin
            if (pass == PASS_COARSE) begin
                windows <= winNext;
            end else begin
                for (int p = 0; p < PIXEL_NUM; p++) begin
                    results[p] <= NP'(peaks[p]) + windows[p].thMinus;
                end
            end
        end
    end

endmodule

// ==== hdl/sifhCore.sv ====
`timescale 1ns/10ps
// SiFH peak finder top level
// bus port, sequencer, filter, histogram, peak tracker and refinement
module sifhCore (
    input  logic                    clk,
    input  logic                    combin_res,
    input  sifhTypesPkg::wbReq_t    wbReq,
    output sifhTypesPkg::wbRsp_t    wbRsp
);
    import sifhParamPkg::*;
    import sifhTypesPkg::*;

    // bus side
    logic sampleAccept;
    logic [NP-1:0] sampleData;

    // sequencing
    sampleIn_t sampleIn;
    pass_e pass;
    logic busy;
    logic passEnd;
    logic [FRAME_W-1:0] frameCount;

    // ********************
    // pipeline
    binBeat_t beat;
    binHit_t hit;
    peakArr_t peaks;
    windowArr_t windows;
    resultArr_t results;

    wbSamplePort i_wbSamplePort (
        .clk(clk), .combin_res(combin_res), .wbReq(wbReq), .wbRsp(wbRsp), .busy(busy),
        .pass(pass), .frameCount(frameCount), .results(results),
        .sampleAccept(sampleAccept), .sampleData(sampleData)
    );

    frameSequencer i_frameSequencer (
        .clk(clk), .combin_res(combin_res), .sampleAccept(sampleAccept),
        .sampleData(sampleData), .sampleOut(sampleIn), .pass(pass), .busy(busy),
        .passEnd(passEnd), .frameCount(frameCount)
    );

    sampleFilter i_sampleFilter (
        .clk(clk), .combin_res(combin_res), .sampleIn(sampleIn), .pass(pass),
        .windows(windows), .beat(beat)
    );

    // pass end also clears histogram and tracker
    binHistogram i_binHistogram (
        .clk(clk), .combin_res(combin_res), .beat(beat), .clear(passEnd), .hit(hit)
    );

    peakTracker i_peakTracker (
        .clk(clk), .combin_res(combin_res), .hit(hit), .clear(passEnd), .peaks(peaks)
    );

    peakRefine i_peakRefine (
        .clk(clk), .combin_res(combin_res), .passEnd(passEnd), .pass(pass), .peaks(peaks),
        .windows(windows), .results(results)
    );

endmodule

// ==== tests/sifhTb.sv ====
`timescale 1ns/10ps
// testbench of the SiFH peak finder
// writes whole frames over Wishbone, replays them through a reference model
// and compares the results read back from the core
module sifhTb;
    import sifhParamPkg::*;
    import sifhTypesPkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int DW = NP + FRAME_W;
    localparam int PASS_LEN = DATA_NUM * PIXEL_NUM * ACQ_NUM;
    localparam int FRAME_LEN = 2 * PASS_LEN;
    localparam int MAX_VAL = 2 ** NP - 1;
    localparam int FRAME_TOTAL = 7;
    localparam int ACK_LIMIT = 50;
    localparam int POLL_LIMIT = 50;
    // about 3 clocks per sample, plus reset, polling and unmapped reads
    localparam int WATCHDOG_CYCLES = FRAME_TOTAL * FRAME_LEN * 3 + 2000;

    logic clk = 1'b0;
    logic combin_res;
    wbReq_t wbReq;
    wbRsp_t wbRsp;

    integer seed;
    logic [NP-1:0] frameSamples [FRAME_LEN];
    int centre [PIXEL_NUM];
    int valA [PIXEL_NUM];
    int valB [PIXEL_NUM];
    int valC [PIXEL_NUM];
    int valD [PIXEL_NUM];
    logic [FRAME_W-1:0] frameNum;
    logic [DW-1:0] rd;

    // reference histogram state
    int refCount [PIXEL_NUM][BIN_NUM];
    int refBest [PIXEL_NUM];
    int refBestBin [PIXEL_NUM];

    // results waiting for the checker
    logic [DW-1:0] gotQ [$];
    logic [DW-1:0] expQ [$];
    int tagQ [$];

    sifhCore i_sifhCore (.clk(clk), .combin_res(combin_res), .wbReq(wbReq), .wbRsp(wbRsp));

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic checkValue(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Errors found");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // ********************
    // bus tasks, called 1 ns after a rising edge
    task automatic waitAck();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > ACK_LIMIT) begin
                $display("bus cycle was never acknowledged by the core");
                $display("Errors found");
                $fatal(1, "no ack");
            end
        end while (!wbRsp.ack);
    endtask

    task automatic wbWrite(input logic [ADR_W-1:0] adr, input logic [DW-1:0] data);
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: data};
        waitAck();
        wbReq = '0;
    endtask

    task automatic wbRead(input logic [ADR_W-1:0] adr, output logic [DW-1:0] data);
        wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
        waitAck();
        data = wbRsp.dat;
        wbReq = '0;
    endtask

    // read status until it reaches the expected value, then check it
    task automatic pollStatus(input logic [DW-1:0] expStatus);
        logic [DW-1:0] status;
        int tries;
        tries = 0;
        wbRead(ADR_SAMPLE, status);
        while (status !== expStatus && tries < POLL_LIMIT) begin
            wbRead(ADR_SAMPLE, status);
            tries++;
        end
        checkValue("status", status, expStatus);
    endtask

    // ********************
    // reference model
    function automatic void clearRef();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            refBest[p] = 0;
            refBestBin[p] = 0;
            for (int b = 0; b < BIN_NUM; b++) begin
                refCount[p][b] = 0;
            end
        end
    endfunction

    // saturating count, strictly greater moves the peak
    function automatic void addHit(input int pix, input int bin);
        if (refCount[pix][bin] < 2 ** PEAK_W - 1) begin
            refCount[pix][bin]++;
        end
        if (refCount[pix][bin] > refBest[pix]) begin
            refBest[pix] = refCount[pix][bin];
            refBestBin[pix] = bin;
        end
    endfunction

    function automatic resultArr_t refFrame();
        int lo [PIXEL_NUM];
        int hi [PIXEL_NUM];
        int s;
        int p;
        int ch;
        resultArr_t res;
        clearRef();
        // coarse pass, top NB bits, no-data dropped
        for (int k = 0; k < PASS_LEN; k++) begin
            p = (k / DATA_NUM) % PIXEL_NUM;
            s = int'(frameSamples[k]);
            if (s != MAX_VAL) begin
                addHit(p, s >> (NP - NB));
            end
        end
        // window around each coarse peak
        for (int q = 0; q < PIXEL_NUM; q++) begin
            ch = refBestBin[q] << (NP - NB);
            if (ch > MAX_VAL - 2 * SB - 1) begin
                lo[q] = MAX_VAL - 2 * SB - 1;
                hi[q] = MAX_VAL - 1;
            end else if (ch <= SB) begin
                lo[q] = 0;
                hi[q] = 2 * SB;
            end else begin
                lo[q] = ch - SB;
                hi[q] = ch + SB;
            end
        end
        clearRef();
        // fine pass, top bin reserved
        for (int k = PASS_LEN; k < FRAME_LEN; k++) begin
            p = (k / DATA_NUM) % PIXEL_NUM;
            s = int'(frameSamples[k]);
            if (s >= lo[p] && s <= hi[p] && s - lo[p] < BIN_NUM - 1) begin
                addHit(p, s - lo[p]);
            end
        end
        for (int q = 0; q < PIXEL_NUM; q++) begin
            res[q] = NP'(refBestBin[q] + lo[q]);
        end
        return res;
    endfunction

    // ********************
    // stimulus generators
    function automatic logic [NP-1:0] noisySample(input int mid, input int spread);
        int v;
        // roughly one in sixteen is no data
        if (($random(seed) & 15) == 0) begin
            return NO_DATA;
        end
        v = mid + ($random(seed) % (spread + 1));
        if (v < 0) begin
            v = 0;
        end else if (v > MAX_VAL - 1) begin
            v = MAX_VAL - 1;
        end
        return NP'(v);
    endfunction

    function automatic void fillCluster(input int spread);
        for (int k = 0; k < FRAME_LEN; k++) begin
            frameSamples[k] = noisySample(centre[(k / DATA_NUM) % PIXEL_NUM], spread);
        end
    endfunction

    function automatic void setPair(input int p, input int a, input int b,
                                    input int c, input int d);
        valA[p] = a;
        valB[p] = b;
        valC[p] = c;
        valD[p] = d;
    endfunction

    // alternate two values per pixel, first one reaches each count first
    function automatic void fillPairs();
        int p;
        for (int k = 0; k < FRAME_LEN; k++) begin
            p = (k / DATA_NUM) % PIXEL_NUM;
            if (k < PASS_LEN) begin
                frameSamples[k] = NP'((k % 2 == 0) ? valA[p] : valB[p]);
            end else begin
                frameSamples[k] = NP'((k % 2 == 0) ? valC[p] : valD[p]);
            end
        end
    endfunction

    task automatic randomCentres();
        for (int p = 0; p < PIXEL_NUM; p++) begin
            centre[p] = $random(seed) & MAX_VAL;
        end
    endtask

    // one frame in, status polled, results queued for the checker
    task automatic runFrame();
        logic [DW-1:0] data;
        resultArr_t expRes;
        expRes = refFrame();
        for (int k = 0; k < PASS_LEN; k++) begin
            wbWrite(ADR_SAMPLE, DW'(frameSamples[k]));
        end
        // coarse pass closed, fine pass running
        pollStatus({frameNum, {(NP - 1){1'b0}}, 1'b1});
        for (int k = PASS_LEN; k < FRAME_LEN; k++) begin
            wbWrite(ADR_SAMPLE, DW'(frameSamples[k]));
        end
        frameNum = frameNum + 1'b1;
        pollStatus({frameNum, NP'(0)});
        for (int p = 0; p < PIXEL_NUM; p++) begin
            wbRead(ADR_W'(int'(ADR_RESULT) + p), data);
            gotQ.push_back(data);
            expQ.push_back(DW'(expRes[p]));
            tagQ.push_back(p);
        end
    endtask

    // ********************
    // checker
    initial begin
        forever begin
            @(posedge clk);
            while (gotQ.size() > 0) begin
                checkValue($sformatf("result[%0d]", tagQ.pop_front()),
                           gotQ.pop_front(), expQ.pop_front());
            end
        end
    end

    // watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    // ********************
    // main sequence
    initial begin
        seed = 32'hda3d_e1a4;
        combin_res = 1'b0;
        wbReq = '0;
        frameNum = '0;
        repeat (5) @(posedge clk);
        #1;
        combin_res = 1'b1;
        @(posedge clk);
        #1;

        // reset state
        wbRead(ADR_SAMPLE, rd);
        checkValue("status", rd, '0);
        for (int p = 0; p < PIXEL_NUM; p++) begin
            wbRead(ADR_W'(int'(ADR_RESULT) + p), rd);
            checkValue($sformatf("result[%0d]", p), rd, '0);
        end

        // clustered frame
        randomCentres();
        fillCluster(6);
        runFrame();

        // window edges, near 0, near full scale and mid scale
        centre = '{3, 250, 128, 77};
        fillCluster(20);
        runFrame();
        centre = '{12, 236, 200, 8};
        fillCluster(12);
        runFrame();

        // ties, single value pixel, empty pixel
        setPair(0, 'h35, 'h95, 50, 44);
        setPair(1, 'h95, 'h35, 140, 150);
        setPair(2, 'h77, 'h77, 'h71, 'h71);
        setPair(3, MAX_VAL, MAX_VAL, MAX_VAL, MAX_VAL);
        fillPairs();
        runFrame();

        // unmapped addresses ignore writes and read zero
        for (int a = 1; a < int'(ADR_RESULT); a++) begin
            wbWrite(ADR_W'(a), DW'('h5a5a));
            wbRead(ADR_W'(a), rd);
            checkValue($sformatf("rdata@%0d", a), rd, '0);
        end

        // back to back frames
        for (int f = 0; f < 3; f++) begin
            randomCentres();
            fillCluster(4 + 3 * f);
            runFrame();
        end

        wait (gotQ.size() == 0);
        @(posedge clk);
        $display("No errors");
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/sifhParamPkg.sv
hdl/sifhTypesPkg.sv
hdl/wbSamplePort.sv
hdl/frameSequencer.sv
hdl/sampleFilter.sv
hdl/binHistogram.sv
hdl/peakTracker.sv
hdl/peakRefine.sv
hdl/sifhCore.sv
tests/sifhTb.sv

// ==== run.sh ====
#!/bin/sh
# build the SiFH testbench with Verilator and run it
# the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/10ps --top-module sifhTb \
    -f tb.f -o sifhSim \
    && ./obj_dir/sifhSim > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^No errors$" sim.log && exit 0 || exit 1
